/* rtl/pcs_blk_pkg.sv */
// ----------------------------------------
// 66-bit block geometry and sync header codes,
// imported by every stage of the receive path
// ----------------------------------------
package pcs_blk_pkg;

localparam int HEAD_W  = 2;
localparam int DATA_W  = 64;
localparam int BLOCK_W = HEAD_W + DATA_W;
localparam int KEEP_W  = DATA_W / 8;

// sync header as received, bit 0 arrives first
typedef logic [HEAD_W-1:0] head_t;

// data block, header bit 0 is 0
localparam head_t SH_DATA = 2'b10;
// control block, header bit 0 is 1
localparam head_t SH_CTRL = 2'b01;

endpackage

/* rtl/pcs_dec_pkg.sv */
// ----------------------------------------
// block type bytes and the two payload views
// used when decoding a 64-bit block
// ----------------------------------------
package pcs_dec_pkg;

// start in lane 0 and start in lane 4 reported apart
localparam int START_N = 2;

typedef enum logic [7:0] {
	BT_IDLE   = 8'h1e,
	BT_START0 = 8'h78,
	BT_START4 = 8'h33,
	BT_TERM0  = 8'h87,
	BT_TERM1  = 8'h99,
	BT_TERM2  = 8'haa,
	BT_TERM3  = 8'hb4,
	BT_TERM4  = 8'hcc,
	BT_TERM5  = 8'hd2,
	BT_TERM6  = 8'he1,
	BT_TERM7  = 8'hff,
	BT_ORD    = 8'h4b
} blk_type_t;

// type byte sits in the low byte, first on the wire
typedef struct packed {
	logic [55:0] fields;
	blk_type_t   btype;
} ctrl_blk_t;

typedef union packed {
	logic [7:0][7:0] bytes;
	ctrl_blk_t       ctrl;
} payload_u;

endpackage

/* rtl/gearbox_rx.sv */
// ----------------------------------------
// 64 to 66 bit receive gearbox, 33 words in
// give 32 blocks out, slip moves boundary 1 bit
// ----------------------------------------
`timescale 1ns/1ns
module gearbox_rx
	import pcs_blk_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              lock_v_i,
	input  logic [DATA_W-1:0] data_i,
	input  logic              slip_v_i,
	output logic              valid_o,
	output head_t             head_o,
	output logic [DATA_W-1:0] data_o
);
localparam int BUF_W  = 2 * DATA_W;
localparam int WIDE_W = BUF_W + HEAD_W;
localparam int CNT_W  = $clog2(WIDE_W + 1);

logic [BUF_W-1:0]  buf_q;
logic [CNT_W-1:0]  cnt_q;
logic              off_q;
logic [WIDE_W-1:0] wide;
logic [CNT_W-1:0]  avail;
logic              blk_rdy;

always_comb begin
	// new word lands just above the bits still held
	wide  = {{HEAD_W{1'b0}}, buf_q} | ({{(WIDE_W-DATA_W){1'b0}}, data_i} << cnt_q);
	avail = cnt_q + CNT_W'(DATA_W);
	// pending slip drops the oldest bit
	if (off_q) begin
		wide  = wide >> 1;
		avail = avail - 1'b1;
	end
	blk_rdy = (avail >= CNT_W'(BLOCK_W));
end

always_ff @(posedge clk or negedge rst_n_i) begin
	if (~rst_n_i) begin
		buf_q   <= '0;
		cnt_q   <= '0;
		off_q   <= 1'b0;
		valid_o <= 1'b0;
	end else if (~lock_v_i) begin
		buf_q   <= '0;
		cnt_q   <= '0;
		off_q   <= 1'b0;
		valid_o <= 1'b0;
	end else begin
		off_q   <= slip_v_i;
		valid_o <= blk_rdy;
		if (blk_rdy) begin
			buf_q <= BUF_W'(wide >> BLOCK_W);
			cnt_q <= avail - CNT_W'(BLOCK_W);
		end else begin
			buf_q <= wide[BUF_W-1:0];
			cnt_q <= avail;
		end
	end
end

always_ff @(posedge clk) begin
	if (blk_rdy) begin
		head_o <= head_t'(wide[HEAD_W-1:0]);
		data_o <= wide[BLOCK_W-1:HEAD_W];
	end
end

endmodule

/* rtl/block_sync_rx.sv */
// ----------------------------------------
// clause 49 style block lock, slips on bad
// headers until SH_LOCK_N good ones in a row
// ----------------------------------------
`timescale 1ns/1ns
module block_sync_rx
	import pcs_blk_pkg::*;
#(
	parameter int SH_LOCK_N = 64,
	parameter int SH_BAD_N  = 16
)(
	input  logic  clk,
	input  logic  rst_n_i,
	input  logic  signal_v_i,
	input  logic  valid_i,
	input  head_t head_i,
	output logic  slip_v_o,
	output logic  lock_v_o
);
localparam int WIN_N    = 64;
localparam int SETTLE_N = 2;
localparam int GOOD_W   = $clog2(SH_LOCK_N + 1);
localparam int BAD_W    = $clog2(SH_BAD_N + 1);
localparam int WIN_W    = $clog2(WIN_N);

logic              sh_ok;
logic [GOOD_W-1:0] good_cnt_q;
logic [BAD_W-1:0]  bad_cnt_q;
logic [WIN_W-1:0]  win_cnt_q;
logic [1:0]        settle_q;

// only 01 and 10 are legal
assign sh_ok = (head_i == SH_DATA) | (head_i == SH_CTRL);

always_ff @(posedge clk or negedge rst_n_i) begin
	if (~rst_n_i) begin
		slip_v_o   <= 1'b0;
		lock_v_o   <= 1'b0;
		good_cnt_q <= '0;
		bad_cnt_q  <= '0;
		win_cnt_q  <= '0;
		settle_q   <= '0;
	end else if (~signal_v_i) begin
		slip_v_o   <= 1'b0;
		lock_v_o   <= 1'b0;
		good_cnt_q <= '0;
		bad_cnt_q  <= '0;
		win_cnt_q  <= '0;
		settle_q   <= '0;
	end else begin
		slip_v_o <= 1'b0;
		if (valid_i & ~lock_v_o) begin
			if (settle_q != '0) begin
				// blocks still formed on the old boundary
				settle_q <= settle_q - 1'b1;
			end else if (sh_ok) begin
				good_cnt_q <= good_cnt_q + 1'b1;
				if (good_cnt_q == GOOD_W'(SH_LOCK_N - 1)) begin
					lock_v_o   <= 1'b1;
					good_cnt_q <= '0;
					bad_cnt_q  <= '0;
					win_cnt_q  <= '0;
				end
			end else begin
				slip_v_o   <= 1'b1;
				good_cnt_q <= '0;
				settle_q   <= 2'(SETTLE_N);
			end
		end else if (valid_i) begin
			// window counter wraps every 64 headers
			win_cnt_q <= win_cnt_q + 1'b1;
			if (~sh_ok) begin
				bad_cnt_q <= bad_cnt_q + 1'b1;
			end
			if (~sh_ok && (bad_cnt_q == BAD_W'(SH_BAD_N - 1))) begin
				lock_v_o <= 1'b0;
			end else if (win_cnt_q == WIN_W'(WIN_N - 1)) begin
				bad_cnt_q <= '0;
			end
		end
	end
end

endmodule

/* rtl/descrambler_rx.sv */
// ----------------------------------------
// self-synchronous x^58 + x^39 + 1 descrambler
// over the 64-bit payload, one cycle latency
// ----------------------------------------
`timescale 1ns/1ns
module descrambler_rx
	import pcs_blk_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              valid_i,
	input  logic [DATA_W-1:0] scram_i,
	output logic [DATA_W-1:0] data_o
);
localparam int STATE_W = 58;
localparam int TAP_N   = 39;

// state_q[STATE_W-1] holds the most recent received bit
logic [STATE_W-1:0]        state_q;
logic [DATA_W+STATE_W-1:0] ext;
logic [DATA_W-1:0]         plain;

always_comb begin
	ext = {scram_i, state_q};
	for (int i = 0; i < DATA_W; i++) begin
		plain[i] = ext[STATE_W+i] ^ ext[STATE_W-TAP_N+i] ^ ext[i];
	end
end

always_ff @(posedge clk or negedge rst_n_i) begin
	if (~rst_n_i) begin
		state_q <= '0;
	end else if (valid_i) begin
		state_q <= scram_i[DATA_W-1:DATA_W-STATE_W];
	end
end

always_ff @(posedge clk) begin
	if (valid_i) begin
		data_o <= plain;
	end
end

endmodule

/* rtl/dec_lite_rx.sv */
// ----------------------------------------
// decodes one block into lite MAC strobes,
// data in XGMII lane order and byte keep
// ----------------------------------------
`timescale 1ns/1ns
module dec_lite_rx
	import pcs_blk_pkg::*, pcs_dec_pkg::*;
(
	input  head_t              head_i,
	input  payload_u           data_i,
	output logic               ctrl_v_o,
	output logic               idle_v_o,
	output logic [START_N-1:0] start_v_o,
	output logic               term_v_o,
	output logic               err_v_o,
	output logic               ord_v_o,
	output logic [DATA_W-1:0]  data_o,
	output logic [KEEP_W-1:0]  keep_o
);
logic [3:0] term_n;

always_comb begin
	ctrl_v_o  = 1'b0;
	idle_v_o  = 1'b0;
	start_v_o = '0;
	term_v_o  = 1'b0;
	err_v_o   = 1'b0;
	ord_v_o   = 1'b0;
	data_o    = data_i.bytes;
	keep_o    = '0;
	case (head_i)
		SH_DATA: keep_o = '1;
		SH_CTRL: begin
			ctrl_v_o = 1'b1;
			case (data_i.ctrl.btype)
				BT_IDLE: begin
					// non zero control codes mean /E/
					idle_v_o = (data_i.ctrl.fields == '0);
					err_v_o  = (data_i.ctrl.fields != '0);
				end
				BT_START0: begin
					start_v_o[0] = 1'b1;
					keep_o       = 8'hfe;
				end
				BT_START4: begin
					start_v_o[1] = 1'b1;
					keep_o       = 8'he0;
				end
				BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
				BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7: term_v_o = 1'b1;
				BT_ORD: ord_v_o = 1'b1;
				default: err_v_o = 1'b1;
			endcase
		end
		default: err_v_o = 1'b1;
	endcase

	// bytes in front of the terminate character
	case (data_i.ctrl.btype)
		BT_TERM1: term_n = 4'd1;
		BT_TERM2: term_n = 4'd2;
		BT_TERM3: term_n = 4'd3;
		BT_TERM4: term_n = 4'd4;
		BT_TERM5: term_n = 4'd5;
		BT_TERM6: term_n = 4'd6;
		BT_TERM7: term_n = 4'd7;
		default: term_n = 4'd0;
	endcase

	// D0 sits behind the type byte, move it to lane 0
	if (term_v_o) begin
		data_o = {8'h00, data_i.bytes[7:1]};
		keep_o = KEEP_W'((16'd1 << term_n) - 16'd1);
	end
end

endmodule

/* rtl/pcs_rx.sv */
// ----------------------------------------
// single lane PCS receive top, gearbox then
// block lock, descrambler and lite decoder
// ----------------------------------------
`timescale 1ns/1ns
module pcs_rx
	import pcs_blk_pkg::*, pcs_dec_pkg::*;
#(
	parameter int SH_LOCK_N = 64,
	parameter int SH_BAD_N  = 16
)(
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               serdes_lock_v_i,
	input  logic [DATA_W-1:0]  serdes_data_i,
	output logic               valid_o,
	output logic               ctrl_v_o,
	output logic               idle_v_o,
	output logic [START_N-1:0] start_v_o,
	output logic               term_v_o,
	output logic               err_v_o,
	output logic               ord_v_o,
	output logic [DATA_W-1:0]  data_o,
	output logic [KEEP_W-1:0]  keep_o,
	output logic               lock_v_o
);
logic              blk_v;
head_t             blk_head;
logic [DATA_W-1:0] blk_data;
logic              slip_v;
logic              lock_v;
logic              descr_v;
head_t             head_q;
payload_u          descr_data;

gearbox_rx m_gearbox_rx (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.lock_v_i(serdes_lock_v_i),
	.data_i(serdes_data_i),
	.slip_v_i(slip_v),
	.valid_o(blk_v),
	.head_o(blk_head),
	.data_o(blk_data)
);

block_sync_rx #(
	.SH_LOCK_N(SH_LOCK_N),
	.SH_BAD_N(SH_BAD_N)
) m_block_sync_rx (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.signal_v_i(serdes_lock_v_i),
	.valid_i(blk_v),
	.head_i(blk_head),
	.slip_v_o(slip_v),
	.lock_v_o(lock_v)
);

descrambler_rx m_descrambler_rx (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.valid_i(blk_v),
	.scram_i(blk_data),
	.data_o(descr_data)
);

// header follows the descrambler by one register
// data header when idle keeps every strobe low
// only blocks taken under lock reach the output
always_ff @(posedge clk or negedge rst_n_i) begin
	if (~rst_n_i) begin
		descr_v <= 1'b0;
		head_q  <= SH_DATA;
	end else begin
		descr_v <= blk_v & lock_v;
		head_q  <= (blk_v & lock_v) ? blk_head : SH_DATA;
	end
end

dec_lite_rx m_dec_lite_rx (
	.head_i(head_q),
	.data_i(descr_data),
	.ctrl_v_o(ctrl_v_o),
	.idle_v_o(idle_v_o),
	.start_v_o(start_v_o),
	.term_v_o(term_v_o),
	.err_v_o(err_v_o),
	.ord_v_o(ord_v_o),
	.data_o(data_o),
	.keep_o(keep_o)
);

assign valid_o  = descr_v & lock_v;
assign lock_v_o = lock_v;

endmodule

/* tb/pcs_rx_tb.sv */
// ----------------------------------------
// testbench for the PCS receive path, scrambles
// and packs records from the test data file,
// then checks every block that valid_o marks
// ----------------------------------------
`timescale 1ns/1ns
module pcs_rx_tb
	import pcs_blk_pkg::*, pcs_dec_pkg::*;
();
// {ctrl, idle, start[1:0], term, err, ord}
typedef logic [START_N+4:0] strobe_t;

localparam int IDLE_PAD = 400;
localparam int BURST_N  = 32;
localparam logic [DATA_W-1:0] IDLE_PAY = 64'h1e;

logic               clk;
logic               rst_n;
logic               serdes_lock_v;
logic [DATA_W-1:0]  serdes_data;
logic               valid_o;
logic               ctrl_v_o;
logic               idle_v_o;
logic [START_N-1:0] start_v_o;
logic               term_v_o;
logic               err_v_o;
logic               ord_v_o;
logic [DATA_W-1:0]  data_o;
logic [KEEP_W-1:0]  keep_o;
logic               lock_v_o;

// blocks as sent, record index or -1 for padding
head_t             b_head[$];
logic [DATA_W-1:0] b_pay[$];
int                b_rec[$];
string             r_cls[$];
int                r_inj[$];
bit                r_seen[$];
int                blk_at_word[int];
bit                bitq[$];
logic [DATA_W-1:0] words[$];

int n_words = 0;
int cur_word = -10;
int errors = 0;
int checked = 0;
int drops = 0;
int n_bursts = 0;
bit started = 0;
bit prev_lock = 0;
bit ever_locked = 0;

pcs_rx pcs_rx_i (
	.clk(clk),
	.rst_n_i(rst_n),
	.serdes_lock_v_i(serdes_lock_v),
	.serdes_data_i(serdes_data),
	.valid_o(valid_o),
	.ctrl_v_o(ctrl_v_o),
	.idle_v_o(idle_v_o),
	.start_v_o(start_v_o),
	.term_v_o(term_v_o),
	.err_v_o(err_v_o),
	.ord_v_o(ord_v_o),
	.data_o(data_o),
	.keep_o(keep_o),
	.lock_v_o(lock_v_o)
);

always #20 clk = ~clk;

function automatic int term_bytes(input logic [7:0] t);
	case (t)
		8'h87: return 0;
		8'h99: return 1;
		8'haa: return 2;
		8'hb4: return 3;
		8'hcc: return 4;
		8'hd2: return 5;
		8'he1: return 6;
		8'hff: return 7;
		default: return -1;
	endcase
endfunction

// expected decode from the block rules
function automatic void expect_block(input head_t h, input logic [DATA_W-1:0] p,
		output logic [DATA_W-1:0] d, output logic [KEEP_W-1:0] k, output strobe_t s);
	int n;
	logic c, idl, trm, er, ord;
	logic [1:0] st;
	c = 0;
	idl = 0;
	trm = 0;
	er = 0;
	ord = 0;
	st = '0;
	d = p;
	k = '0;
	n = term_bytes(p[7:0]);
	if (h == SH_DATA) begin
		k = '1;
	end else if (h == SH_CTRL) begin
		c = 1;
		if (n >= 0) begin
			trm = 1;
			d = p >> 8;
			k = KEEP_W'((16'd1 << n) - 16'd1);
		end else begin
			case (p[7:0])
				8'h1e: begin
					idl = (p[63:8] == '0);
					er  = (p[63:8] != '0);
				end
				8'h78: begin
					st[0] = 1;
					k = 8'hfe;
				end
				8'h33: begin
					st[1] = 1;
					k = 8'he0;
				end
				8'h4b: ord = 1;
				default: er = 1;
			endcase
		end
	end else begin
		er = 1;
	end
	s = {c, idl, st, trm, er, ord};
endfunction

function automatic string class_name(input strobe_t s);
	if (s[1]) return "err";
	if (s[2]) return "term";
	if (s[3]) return "start0";
	if (s[4]) return "start4";
	if (s[0]) return "ord";
	if (s[5]) return "idle";
	return "data";
endfunction

task automatic check_data(input int b, input payload_u got, input payload_u exp,
		input logic [KEEP_W-1:0] got_keep, input logic [KEEP_W-1:0] exp_keep);
	if (got !== exp || got_keep !== exp_keep) begin
		$display("** Error @%0t: block %0d data %h keep %h, expected %h keep %h",
			$time, b, got, got_keep, exp, exp_keep);
		errors++;
	end
endtask

task automatic check_ctrl(input int b, input strobe_t got, input strobe_t exp);
	if (got !== exp) begin
		$display("** Error @%0t: block %0d strobes %b, expected %b", $time, b, got, exp);
		errors++;
	end
endtask

task automatic check_lock(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		$display("** Error @%0t: %s lock %b, expected %b", $time, what, got, exp);
		errors++;
	end
endtask

task automatic add_block(input head_t h, input logic [DATA_W-1:0] p, input int rec);
	b_head.push_back(h);
	b_pay.push_back(p);
	b_rec.push_back(rec);
endtask

task automatic load_records(input int fd);
	string line;
	string cls;
	head_t h;
	head_t hs;
	logic [DATA_W-1:0] p;
	logic [DATA_W-1:0] d;
	logic [KEEP_W-1:0] k;
	strobe_t s;
	int inj;
	int rec;
	while (!$feof(fd)) begin
		if ($fgets(line, fd) == 0) continue;
		if (line.len() < 4 || line[0] == "#") continue;
		void'($sscanf(line, "%b %h %s %d", h, p, cls, inj));
		rec = r_cls.size();
		hs = (inj != 0) ? head_t'(2'b11) : h;
		expect_block(hs, p, d, k, s);
		if (class_name(s) != cls) begin
			$display("test data record %0d says %s but decodes as %s",
				rec, cls, class_name(s));
			errors++;
		end
		r_cls.push_back(cls);
		r_inj.push_back(inj);
		r_seen.push_back(0);
		if (inj == 2) begin
			// corrupted burst, then idles to relock
			n_bursts++;
			repeat (BURST_N) add_block(hs, p, rec);
			repeat (IDLE_PAD) add_block(SH_CTRL, IDLE_PAY, -1);
		end else begin
			add_block(hs, p, rec);
		end
	end
endtask

// scramble, serialize from a random bit offset, pack into words
task automatic build_stream();
	logic [57:0] sh;
	logic [DATA_W-1:0] w;
	int lead;
	bit o;
	sh = '0;
	lead = int'($urandom % 66);
	repeat (lead) bitq.push_back(bit'($urandom & 1));
	for (int b = 0; b < b_head.size(); b++) begin
		bitq.push_back(b_head[b][0]);
		bitq.push_back(b_head[b][1]);
		for (int i = 0; i < DATA_W; i++) begin
			o = b_pay[b][i] ^ sh[38] ^ sh[57];
			sh = {sh[56:0], o};
			bitq.push_back(o);
		end
		blk_at_word[(bitq.size() - 1) / DATA_W] = b;
	end
	while (bitq.size() > 0) begin
		w = '0;
		for (int i = 0; i < DATA_W && bitq.size() > 0; i++) w[i] = bitq.pop_front();
		words.push_back(w);
	end
	n_words = words.size();
endtask

always @(negedge clk) begin : monitor
	payload_u gd;
	payload_u ed;
	strobe_t gs;
	strobe_t es;
	logic [KEEP_W-1:0] ek;
	int w;
	int b;
	int e0;
	int rec;
	if (rst_n && started) begin
		gs = {ctrl_v_o, idle_v_o, start_v_o, term_v_o, err_v_o, ord_v_o};
		// strobes stay quiet until the first lock, valid_o whenever unlocked
		if (!lock_v_o && (valid_o || (!ever_locked && gs != '0))) begin
			$display("** Error @%0t: output active without block lock", $time);
			errors++;
		end
		if (prev_lock && !lock_v_o) drops++;
		if (lock_v_o) ever_locked = 1;
		if (valid_o) begin
			w = cur_word - 2;
			if (blk_at_word.exists(w)) begin
				b = blk_at_word[w];
				e0 = errors;
				expect_block(b_head[b], b_pay[b], ed, ek, es);
				gd = data_o;
				check_data(b, gd, ed, keep_o, ek);
				check_ctrl(b, gs, es);
				rec = b_rec[b];
				if (rec >= 0 && !r_seen[rec]) begin
					r_seen[rec] = 1;
					checked++;
					$display("test %0d %s: %s", rec, r_cls[rec],
						(errors == e0) ? "ok" : "mismatch");
				end
			end else if (w < n_words) begin
				$display("valid_o rose with no block completed in word %0d", w);
				errors++;
			end
		end
		prev_lock = lock_v_o;
	end
end

initial begin : watchdog
	int limit;
	wait (n_words > 0);
	limit = 2 * b_head.size() * 33 / 32 + 4 * (66 * 3 + 64);
	repeat (limit) @(posedge clk);
	$display("watchdog: the run did not finish within %0d cycles", limit);
	$display("TB FAILED");
	$finish;
end

initial begin
	int fd;
	clk = 0;
	rst_n = 0;
	serdes_lock_v = 0;
	serdes_data = '0;
	void'($urandom(32'hffca9a64));
	fd = $fopen("tb/pcs_rx_testdata.txt", "r");
	if (fd == 0) begin
		$display("could not open the test data file");
		$display("TB FAILED");
		$finish;
	end else begin
		repeat (IDLE_PAD) add_block(SH_CTRL, IDLE_PAY, -1);
		load_records(fd);
		$fclose(fd);
		repeat (4) add_block(SH_CTRL, IDLE_PAY, -1);
		build_stream();
		repeat (4) @(posedge clk);
		#2 rst_n = 1;
		started = 1;
		for (int w = 0; w < n_words + 3; w++) begin
			@(posedge clk);
			#2;
			cur_word = w;
			serdes_lock_v = 1;
			serdes_data = (w < n_words) ? words[w] : '0;
		end
		@(posedge clk);
		#2;
		for (int r = 0; r < r_cls.size(); r++) begin
			if (r_inj[r] != 2 && !r_seen[r]) begin
				$display("record %0d never came out of the DUT", r);
				errors++;
			end
		end
		if (drops != n_bursts) begin
			$display("lock dropped %0d times, expected %0d", drops, n_bursts);
			errors++;
		end
		check_lock("end of run", lock_v_o, 1'b1);
		$display("records %0d, checked %0d, errors %0d", r_cls.size(), checked, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end
end

endmodule

/* tb/pcs_rx_testdata.txt */
# header (binary, bit 0 first on the wire), plaintext payload (hex, byte 0 low)
# expected class, inject (0 none, 1 corrupt header, 2 burst of corrupt headers)
10 0706050403020100 data 0
10 f0debc9a78563412 data 0
01 000000000000001e idle 0
01 d555555555555578 start0 0
10 efcdab8967452301 data 0
01 d555555500000033 start4 0
01 0000000000000087 term 0
01 0000000000001199 term 0
01 00000000002211aa term 0
01 00000000332211b4 term 0
01 00000044332211cc term 0
01 00005544332211d2 term 0
01 00665544332211e1 term 0
01 77665544332211ff term 0
01 000000000200004b ord 0
01 0000000000000052 err 0
01 000000000000071e err 0
10 1122334455667788 err 1
01 000000000000001e err 2
10 0011223344556677 data 0

/* vlog.f */
rtl/pcs_blk_pkg.sv
rtl/pcs_dec_pkg.sv
rtl/gearbox_rx.sv
rtl/block_sync_rx.sv
rtl/descrambler_rx.sv
rtl/dec_lite_rx.sv
rtl/pcs_rx.sv
tb/pcs_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the PCS receive testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f vlog.f --top-module pcs_rx_tb -o sim_pcs_rx
out=$(./obj_dir/sim_pcs_rx)
echo "$out"
if echo "$out" | grep -q "TB PASSED"; then
	exit 0
else
	exit 1
fi
